//--- common/csr_addr_pkg.sv
// CSR address map and constants
`default_nettype none

package csr_addr_pkg;

  typedef logic [11:0] csr_addr_t;   // CSR number

  // Operation carried with every CSR instruction
  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  ////////////////////
  // Machine trap setup and handling
  localparam csr_addr_t CSR_MSTATUS       = 12'h300;
  localparam csr_addr_t CSR_MISA          = 12'h301;
  localparam csr_addr_t CSR_MIE           = 12'h304;
  localparam csr_addr_t CSR_MTVEC         = 12'h305;
  localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;
  localparam csr_addr_t CSR_MHPMEVENT3    = 12'h323;
  localparam csr_addr_t CSR_MSCRATCH      = 12'h340;
  localparam csr_addr_t CSR_MEPC          = 12'h341;
  localparam csr_addr_t CSR_MCAUSE        = 12'h342;
  localparam csr_addr_t CSR_MTVAL         = 12'h343;  // Reads as zero
  localparam csr_addr_t CSR_MIP           = 12'h344;

  ////////////////////
  // Machine counters, lower and upper halves
  localparam csr_addr_t CSR_MCYCLE        = 12'hB00;
  localparam csr_addr_t CSR_MINSTRET      = 12'hB02;
  localparam csr_addr_t CSR_MHPMCOUNTER3  = 12'hB03;
  localparam csr_addr_t CSR_MCYCLEH       = 12'hB80;
  localparam csr_addr_t CSR_MINSTRETH     = 12'hB82;
  localparam csr_addr_t CSR_MHPMCOUNTER3H = 12'hB83;

  // Read-only identification
  localparam csr_addr_t CSR_MVENDORID     = 12'hF11;
  localparam csr_addr_t CSR_MARCHID       = 12'hF12;
  localparam csr_addr_t CSR_MIMPID        = 12'hF13;  // Reads as zero
  localparam csr_addr_t CSR_MHARTID       = 12'hF14;

  ////////////////////
  // Fixed values
  localparam logic [31:0] MISA_VALUE      = 32'h4000_1104;  // MXL=1 with C, I, M
  localparam logic [31:0] MVENDORID_VALUE = 32'h0000_0001;
  localparam logic [31:0] MARCHID_VALUE   = 32'h0000_0023;
  localparam logic [1:0]  PRIV_LVL_M      = 2'b11;          // Only level implemented

  localparam logic [31:0] IRQ_MASK          = 32'h0000_0888;  // MSI, MTI, MEI
  localparam logic [31:0] MSTATUS_RESET_VAL = 32'h0000_1800;  // MPP=M
  localparam logic [31:0] MTVEC_RESET_VAL   = 32'h0000_0001;  // Vectored mode, base 0

  localparam int          NUM_HPM_EVENTS     = 8;
  localparam int          NUM_COUNTERS       = 3;              // mcycle, minstret, mhpm3
  localparam logic [31:0] MCOUNTINHIBIT_MASK = 32'h0000_000D;  // Bits 0, 2, 3

endpackage

`default_nettype wire

//--- common/csr_types_pkg.sv
// CSR field layouts and port structs
`default_nettype none

package csr_types_pkg;

  typedef logic [31:0] csr_word_t;
  typedef logic [63:0] counter_t;

  // mstatus with the M-mode fields only
  typedef struct packed {
    logic [18:0] zero2;
    logic [1:0]  mpp;    // Bits 12:11
    logic [2:0]  zero1;
    logic        mpie;   // Bit 7
    logic [2:0]  zero0;
    logic        mie;    // Bit 3
    logic [2:0]  zero_lo;
  } mstatus_t;

  typedef struct packed {
    logic        irq;    // Interrupt flag
    logic [22:0] zero;
    logic [7:0]  code;   // Exception code
  } mcause_t;

  typedef struct packed {
    logic [23:0] base;   // 256-byte aligned
    logic [5:0]  zero;
    logic [1:0]  mode;
  } mtvec_t;

  // Execute-stage read request
  typedef struct packed {
    logic                  valid;
    logic                  csr_en;
    csr_addr_pkg::csr_op_e op;
    csr_addr_pkg::csr_addr_t addr;
  } csr_rd_req_t;

  // Writeback-stage request, old_value is the value read in execute
  typedef struct packed {
    logic                  valid;
    logic                  csr_en;
    csr_addr_pkg::csr_op_e op;
    csr_addr_pkg::csr_addr_t addr;
    csr_word_t             wdata;
    csr_word_t             old_value;
  } csr_wb_t;

  // Controller commands
  typedef struct packed {
    logic      kill_wb;
    logic      halt_wb;
    logic      save_cause;
    logic      mret;
    mcause_t   cause;
    csr_word_t trap_pc;
  } trap_ctrl_t;

  // Counter events, cycle is bit 0
  typedef struct packed {
    logic jr_stall;
    logic ld_stall;
    logic branch_taken;
    logic branch;
    logic jump;
    logic compressed;
    logic minstret;
    logic cycle;
  } hpm_event_t;

  // One strobe per writable register
  typedef struct packed {
    logic mstatus;
    logic mie;
    logic mtvec;
    logic mscratch;
    logic mepc;
    logic mcause;
    logic mcountinhibit;
    logic mhpmevent3;
    logic mcycle_lo;
    logic mcycle_hi;
    logic minstret_lo;
    logic minstret_hi;
    logic mhpm3_lo;
    logic mhpm3_hi;
  } csr_wr_stb_t;

  typedef struct packed {
    csr_wr_stb_t stb;
    csr_word_t   wdata;   // Already resolved for set and clear
  } csr_wr_sel_t;

  typedef struct packed {
    mstatus_t  mstatus;
    csr_word_t mie;
    mtvec_t    mtvec;
    csr_word_t mscratch;
    csr_word_t mepc;
    mcause_t   mcause;
  } csr_state_t;

  typedef struct packed {
    counter_t  mcycle;
    counter_t  minstret;
    counter_t  mhpmcounter3;
    csr_word_t mcountinhibit;
    csr_word_t mhpmevent3;
  } hpm_state_t;

endpackage

`default_nettype wire

//--- csr_file.f
common/csr_addr_pkg.sv
common/csr_types_pkg.sv
rtl/csr_write_ctrl.sv
rtl/csr_read_mux.sv
trap/machine_trap_regs.sv
hpm/hpm_counters.sv
rtl/csr_file.sv
tb/tb_csr_file.sv

//--- hpm/hpm_counters.sv
// Machine performance counters
`timescale 1ns/1ns
`default_nettype none

module hpm_counters import csr_addr_pkg::*, csr_types_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  csr_wr_sel_t wr_sel_i,   // Software writes
  input  hpm_event_t  events_i,   // Raw event pulses
  output hpm_state_t  state_o
);

  hpm_event_t                events_q;          // Registered events
  csr_word_t                 mcountinhibit_q, mcountinhibit_n;
  logic [NUM_HPM_EVENTS-1:0] mhpmevent3_q;
  logic                      all_off;           // Every implemented counter inhibited
  logic [NUM_COUNTERS-1:0]   wr_lo, wr_hi, inc;
  counter_t                  cnt_q [NUM_COUNTERS];  // 0 mcycle, 1 minstret, 2 mhpm3

  // Inhibit next value, unimplemented bits read zero
  assign mcountinhibit_n = wr_sel_i.stb.mcountinhibit ?
                           (wr_sel_i.wdata & MCOUNTINHIBIT_MASK) : mcountinhibit_q;

  assign all_off = &(mcountinhibit_n | ~MCOUNTINHIBIT_MASK);

  ////////////////////
  // Event registers
  // Flopped for timing, frozen while nothing counts
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      events_q <= '0;
    end else if (!all_off) begin
      events_q <= events_i;
    end
  end

  // Control registers, counters start inhibited
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcountinhibit_q <= MCOUNTINHIBIT_MASK;
      mhpmevent3_q    <= '0;
    end else begin
      mcountinhibit_q <= mcountinhibit_n;
      if (wr_sel_i.stb.mhpmevent3) begin
        mhpmevent3_q <= wr_sel_i.wdata[NUM_HPM_EVENTS-1:0];
      end
    end
  end

  ////////////////////
  // Counter control
  assign wr_lo = {wr_sel_i.stb.mhpm3_lo, wr_sel_i.stb.minstret_lo, wr_sel_i.stb.mcycle_lo};
  assign wr_hi = {wr_sel_i.stb.mhpm3_hi, wr_sel_i.stb.minstret_hi, wr_sel_i.stb.mcycle_hi};

  always_comb begin
    inc[0] = !mcountinhibit_q[0];                          // Every cycle
    inc[1] = !mcountinhibit_q[2] && events_q.minstret;     // Retired instructions
    inc[2] = !mcountinhibit_q[3] && |(events_q & mhpmevent3_q);  // Any selected event
  end

  // Software write to a half wins over the increment
  for (genvar i = 0; i < NUM_COUNTERS; i++) begin : g_cnt
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        cnt_q[i] <= '0;
      end else if (wr_lo[i]) begin
        cnt_q[i][31:0] <= wr_sel_i.wdata;
      end else if (wr_hi[i]) begin
        cnt_q[i][63:32] <= wr_sel_i.wdata;
      end else if (inc[i]) begin
        cnt_q[i] <= cnt_q[i] + 64'd1;
      end
    end
  end

  assign state_o = '{mcycle:        cnt_q[0],
                     minstret:      cnt_q[1],
                     mhpmcounter3:  cnt_q[2],
                     mcountinhibit: mcountinhibit_q,
                     mhpmevent3:    {{(32-NUM_HPM_EVENTS){1'b0}}, mhpmevent3_q}};

  // The write decoder selects one half of a counter at most
  a_half_excl: assert property (@(posedge clk) disable iff (!rst_n)
    (wr_lo & wr_hi) == '0)
    else $error("both halves of a counter written at once");

endmodule

`default_nettype wire

//--- rtl/csr_file.sv
// Machine-mode CSR file top
`timescale 1ns/1ns
`default_nettype none

module csr_file import csr_types_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  csr_word_t   hart_id_i,
  input  csr_rd_req_t rd_req_i,        // Execute-stage read
  input  csr_wb_t     wb_i,            // Writeback-stage write
  input  trap_ctrl_t  ctrl_i,          // Controller commands
  input  hpm_event_t  events_i,
  input  csr_word_t   mip_i,
  output csr_word_t   rdata_o,
  output logic        illegal_o,
  output logic        counter_read_o,
  output csr_word_t   mie_o,
  output csr_word_t   mepc_o,
  output mtvec_t      mtvec_o,
  output logic        m_irq_enable_o
);

  csr_wr_sel_t wr_sel;
  csr_state_t  csr_state;
  hpm_state_t  hpm_state;
  hpm_event_t  events_int;

  // Cycle event is always active
  always_comb begin
    events_int       = events_i;
    events_int.cycle = 1'b1;
  end

  ////////////////////
  // Write side
  csr_write_ctrl u_write_ctrl (
    .wb_i     (wb_i),
    .ctrl_i   (ctrl_i),
    .wr_sel_o (wr_sel)
  );

  machine_trap_regs u_trap_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .wr_sel_i       (wr_sel),
    .ctrl_i         (ctrl_i),
    .state_o        (csr_state),
    .mie_o          (mie_o),
    .mepc_o         (mepc_o),
    .mtvec_o        (mtvec_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  hpm_counters u_hpm (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_sel_i (wr_sel),
    .events_i (events_int),
    .state_o  (hpm_state)
  );

  ////////////////////
  // Read side
  csr_read_mux u_read_mux (
    .rd_req_i       (rd_req_i),
    .csr_state_i    (csr_state),
    .hpm_state_i    (hpm_state),
    .mip_i          (mip_i),
    .hart_id_i      (hart_id_i),
    .rdata_o        (rdata_o),
    .illegal_o      (illegal_o),
    .counter_read_o (counter_read_o)
  );

endmodule

`default_nettype wire

//--- rtl/csr_read_mux.sv
// CSR execute-stage read port
`timescale 1ns/1ns
`default_nettype none

module csr_read_mux import csr_addr_pkg::*, csr_types_pkg::*; (
  input  csr_rd_req_t rd_req_i,
  input  csr_state_t  csr_state_i,   // Trap registers
  input  hpm_state_t  hpm_state_i,   // Counters and selectors
  input  csr_word_t   mip_i,         // Pending interrupts, not stored here
  input  csr_word_t   hart_id_i,
  output csr_word_t   rdata_o,
  output logic        illegal_o,
  output logic        counter_read_o
);

  logic req_act;     // Valid CSR instruction in execute
  logic unknown;     // Address not implemented
  logic is_counter;  // Address is a counter half
  logic ro_write;    // Write to a read-only space

  assign req_act = rd_req_i.valid && rd_req_i.csr_en;

  ////////////////////
  // Read data select
  always_comb begin
    unknown    = 1'b0;
    is_counter = 1'b0;
    case (rd_req_i.addr)
      CSR_MSTATUS:       rdata_o = csr_state_i.mstatus;
      CSR_MISA:          rdata_o = MISA_VALUE;
      CSR_MIE:           rdata_o = csr_state_i.mie;
      CSR_MTVEC:         rdata_o = csr_state_i.mtvec;
      CSR_MSCRATCH:      rdata_o = csr_state_i.mscratch;
      CSR_MEPC:          rdata_o = csr_state_i.mepc;
      CSR_MCAUSE:        rdata_o = csr_state_i.mcause;
      CSR_MIP:           rdata_o = mip_i;
      CSR_MHARTID:       rdata_o = hart_id_i;
      CSR_MVENDORID:     rdata_o = MVENDORID_VALUE;
      CSR_MARCHID:       rdata_o = MARCHID_VALUE;
      CSR_MIMPID,
      CSR_MTVAL:         rdata_o = '0;                      // Legal, hardwired zero
      CSR_MCOUNTINHIBIT: rdata_o = hpm_state_i.mcountinhibit;
      CSR_MHPMEVENT3:    rdata_o = hpm_state_i.mhpmevent3;
      CSR_MCYCLE: begin
        rdata_o    = hpm_state_i.mcycle[31:0];
        is_counter = 1'b1;
      end
      CSR_MINSTRET: begin
        rdata_o    = hpm_state_i.minstret[31:0];
        is_counter = 1'b1;
      end
      CSR_MHPMCOUNTER3: begin
        rdata_o    = hpm_state_i.mhpmcounter3[31:0];
        is_counter = 1'b1;
      end
      CSR_MCYCLEH: begin
        rdata_o    = hpm_state_i.mcycle[63:32];
        is_counter = 1'b1;
      end
      CSR_MINSTRETH: begin
        rdata_o    = hpm_state_i.minstret[63:32];
        is_counter = 1'b1;
      end
      CSR_MHPMCOUNTER3H: begin
        rdata_o    = hpm_state_i.mhpmcounter3[63:32];
        is_counter = 1'b1;
      end
      default: begin                                        // Debug, trigger, aliases too
        rdata_o = '0;
        unknown = 1'b1;
      end
    endcase
  end

  // Top two address bits 11 mark a read-only CSR
  assign ro_write = (rd_req_i.op != CSR_OP_READ) && (rd_req_i.addr[11:10] == 2'b11);

  assign illegal_o      = req_act && (unknown || ro_write);
  assign counter_read_o = req_act && is_counter;   // Lets the core bypass stale counts

  // Decode faults must never appear on an idle slot
  always_comb begin
    assert final (!illegal_o || rd_req_i.valid)
      else $error("illegal access flagged without a valid request");
  end

endmodule

`default_nettype wire

//--- rtl/csr_write_ctrl.sv
// CSR writeback operation and decode
`timescale 1ns/1ns
`default_nettype none

module csr_write_ctrl import csr_addr_pkg::*, csr_types_pkg::*; (
  input  csr_wb_t     wb_i,      // Writeback request
  input  trap_ctrl_t  ctrl_i,    // Kill and halt from the controller
  output csr_wr_sel_t wr_sel_o   // Strobes plus resolved data
);

  logic      wr_en;      // Request survives gating
  csr_word_t wdata_int;

  // Killed or halted writeback never reaches a register
  assign wr_en = wb_i.valid && wb_i.csr_en && (wb_i.op != CSR_OP_READ) &&
                 !ctrl_i.kill_wb && !ctrl_i.halt_wb;

  ////////////////////
  // Read-modify-write against the value read in execute
  always_comb begin
    case (wb_i.op)
      CSR_OP_SET:   wdata_int = wb_i.old_value | wb_i.wdata;
      CSR_OP_CLEAR: wdata_int = wb_i.old_value & ~wb_i.wdata;
      default:      wdata_int = wb_i.wdata;   // WRITE, READ is gated above
    endcase
  end

  ////////////////////
  // Address decode, the only one on the write side
  always_comb begin
    wr_sel_o       = '0;
    wr_sel_o.wdata = wdata_int;
    if (wr_en) begin
      case (wb_i.addr)
        CSR_MSTATUS:       wr_sel_o.stb.mstatus       = 1'b1;
        CSR_MIE:           wr_sel_o.stb.mie           = 1'b1;
        CSR_MTVEC:         wr_sel_o.stb.mtvec         = 1'b1;
        CSR_MSCRATCH:      wr_sel_o.stb.mscratch      = 1'b1;
        CSR_MEPC:          wr_sel_o.stb.mepc          = 1'b1;
        CSR_MCAUSE:        wr_sel_o.stb.mcause        = 1'b1;
        CSR_MCOUNTINHIBIT: wr_sel_o.stb.mcountinhibit = 1'b1;
        CSR_MHPMEVENT3:    wr_sel_o.stb.mhpmevent3    = 1'b1;
        CSR_MCYCLE:        wr_sel_o.stb.mcycle_lo     = 1'b1;
        CSR_MCYCLEH:       wr_sel_o.stb.mcycle_hi     = 1'b1;
        CSR_MINSTRET:      wr_sel_o.stb.minstret_lo   = 1'b1;
        CSR_MINSTRETH:     wr_sel_o.stb.minstret_hi   = 1'b1;
        CSR_MHPMCOUNTER3:  wr_sel_o.stb.mhpm3_lo      = 1'b1;
        CSR_MHPMCOUNTER3H: wr_sel_o.stb.mhpm3_hi      = 1'b1;
        default: ;                                    // Read-only or unknown, no effect
      endcase
    end
  end

  // Receivers rely on a single register being touched per write
  always_comb begin
    assert final ($onehot0(wr_sel_o.stb))
      else $error("more than one CSR write strobe");
  end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the CSR file testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_csr_file -Mdir obj_dir -f csr_file.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit "$build_status"
fi

./obj_dir/Vtb_csr_file
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "simulation failed with status $sim_status"
  exit "$sim_status"
fi

echo "simulation finished"
exit 0

//--- tb/tb_csr_file.sv
// CSR file directed testbench
`timescale 1ns/1ns
`default_nettype none

module tb_csr_file import csr_addr_pkg::*, csr_types_pkg::*; ();

  localparam int          CLK_PERIOD = 10;
  localparam logic [31:0] SEED       = 32'ha0b7cfff;

  // Cycle budget per test with the watchdog at twice the sum
  localparam int RESET_CYCLES = 8;
  localparam int CONST_CYCLES = 60;
  localparam int RW_CYCLES    = 60;
  localparam int LEGAL_CYCLES = 20;
  localparam int TRAP_CYCLES  = 30;
  localparam int CNT_CYCLES   = 160;
  localparam int WATCHDOG_NS  = 2 * CLK_PERIOD * (RESET_CYCLES + CONST_CYCLES + RW_CYCLES +
                                                  LEGAL_CYCLES + TRAP_CYCLES + CNT_CYCLES);

  localparam csr_addr_t   UNKNOWN_ADDR = 12'h3A0;       // pmpcfg0 is not implemented
  localparam csr_addr_t   DCSR_ADDR    = 12'h7B0;       // Debug CSR which is dropped
  localparam csr_word_t   MSTATUS_MIE  = 32'h0000_0008;
  localparam csr_word_t   MSTATUS_MPIE = 32'h0000_0080;
  localparam csr_word_t   TRAP_CAUSE   = 32'h8000_000B;  // Machine external interrupt
  localparam hpm_event_t  EV_MINSTRET  = 8'h02;
  localparam hpm_event_t  EV_JUMP      = 8'h08;
  localparam hpm_event_t  EV_BRANCH    = 8'h10;

  logic        clk = 1'b0;
  logic        rst_n;
  csr_word_t   hart_id_i;
  csr_rd_req_t rd_req_i;
  csr_wb_t     wb_i;
  trap_ctrl_t  ctrl_i;
  hpm_event_t  events_i;
  csr_word_t   mip_i;
  csr_word_t   rdata_o;
  logic        illegal_o;
  logic        counter_read_o;
  csr_word_t   mie_o;
  csr_word_t   mepc_o;
  mtvec_t      mtvec_o;
  logic        m_irq_enable_o;

  int          err_cnt = 0;
  csr_word_t   scratch_model;   // Expected mscratch

  always #(CLK_PERIOD / 2) clk = ~clk;

  csr_file u_csr_file (
    .clk            (clk),
    .rst_n          (rst_n),
    .hart_id_i      (hart_id_i),
    .rd_req_i       (rd_req_i),
    .wb_i           (wb_i),
    .ctrl_i         (ctrl_i),
    .events_i       (events_i),
    .mip_i          (mip_i),
    .rdata_o        (rdata_o),
    .illegal_o      (illegal_o),
    .counter_read_o (counter_read_o),
    .mie_o          (mie_o),
    .mepc_o         (mepc_o),
    .mtvec_o        (mtvec_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  ////////////////////
  // Helpers
  task automatic check(input string name, input csr_word_t actual, input csr_word_t expected);
    if (actual !== expected) begin
      err_cnt++;
      $display("mismatch %s actual 0x%h expected 0x%h", name, actual, expected);
      $display("Done: errors found");
      $fatal(1, "stopping at first error");
    end
  endtask

  // One-cycle writeback request with kill and halt alongside
  task automatic csr_write(input csr_op_e op, input csr_addr_t addr, input csr_word_t wdata,
                           input csr_word_t old_value, input logic kill, input logic halt);
    @(posedge clk);
    wb_i <= '{valid: 1'b1, csr_en: 1'b1, op: op, addr: addr, wdata: wdata,
              old_value: old_value};
    ctrl_i.kill_wb <= kill;
    ctrl_i.halt_wb <= halt;
    @(posedge clk);                 // Register loads here
    wb_i           <= '0;
    ctrl_i.kill_wb <= 1'b0;
    ctrl_i.halt_wb <= 1'b0;
  endtask

  task automatic csr_read(input csr_op_e op, input csr_addr_t addr, output csr_word_t rdata,
                          output logic illegal, output logic cnt_rd);
    @(posedge clk);
    rd_req_i <= '{valid: 1'b1, csr_en: 1'b1, op: op, addr: addr};
    @(negedge clk);                 // Read port settled
    rdata   = rdata_o;
    illegal = illegal_o;
    cnt_rd  = counter_read_o;
    @(posedge clk);
    rd_req_i <= '0;
  endtask

  task automatic expect_read(input string name, input csr_addr_t addr, input csr_word_t exp);
    csr_word_t rdata;
    logic      illegal;
    logic      cnt_rd;
    csr_read(CSR_OP_READ, addr, rdata, illegal, cnt_rd);
    check(name, rdata, exp);
    check({name, " illegal"}, 32'(illegal), 32'h0);
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(posedge clk);
  endtask

  // Separate single-cycle pulses
  task automatic pulse_events(input hpm_event_t ev, input csr_word_t count);
    repeat (count) begin
      @(posedge clk);
      events_i <= ev;
      @(posedge clk);
      events_i <= '0;
    end
  endtask

  ////////////////////
  // Tests
  task automatic test_reset_constants();
    expect_read("mstatus", CSR_MSTATUS, MSTATUS_RESET_VAL);
    expect_read("mtvec", CSR_MTVEC, MTVEC_RESET_VAL);
    expect_read("misa", CSR_MISA, MISA_VALUE);
    expect_read("mvendorid", CSR_MVENDORID, MVENDORID_VALUE);
    expect_read("marchid", CSR_MARCHID, MARCHID_VALUE);
    expect_read("mhartid", CSR_MHARTID, hart_id_i);
    expect_read("mip", CSR_MIP, mip_i);               // Passed straight through
    idle(20);                                         // Counters inhibited out of reset
    expect_read("mcycle", CSR_MCYCLE, 32'h0);
    expect_read("mcycleh", CSR_MCYCLEH, 32'h0);
    expect_read("mcountinhibit", CSR_MCOUNTINHIBIT, MCOUNTINHIBIT_MASK);
    @(negedge clk);
    check("m_irq_enable_o", 32'(m_irq_enable_o), 32'h0);
  endtask

  task automatic test_write_set_clear();
    csr_word_t r;
    r = $urandom;
    csr_write(CSR_OP_WRITE, CSR_MSCRATCH, r, 32'h0, 1'b0, 1'b0);
    scratch_model = r;
    expect_read("mscratch write", CSR_MSCRATCH, scratch_model);
    r = $urandom;
    csr_write(CSR_OP_SET, CSR_MSCRATCH, r, scratch_model, 1'b0, 1'b0);
    scratch_model = scratch_model | r;
    expect_read("mscratch set", CSR_MSCRATCH, scratch_model);
    r = $urandom;
    csr_write(CSR_OP_CLEAR, CSR_MSCRATCH, r, scratch_model, 1'b0, 1'b0);
    scratch_model = scratch_model & ~r;
    expect_read("mscratch clear", CSR_MSCRATCH, scratch_model);

    // Field legalisation
    r = $urandom;
    csr_write(CSR_OP_WRITE, CSR_MIE, r, 32'h0, 1'b0, 1'b0);
    expect_read("mie", CSR_MIE, r & IRQ_MASK);
    check("mie_o", mie_o, r & IRQ_MASK);
    r = $urandom | 32'h1;                             // Odd address
    csr_write(CSR_OP_WRITE, CSR_MEPC, r, 32'h0, 1'b0, 1'b0);
    expect_read("mepc", CSR_MEPC, r & ~32'h1);
    check("mepc_o", mepc_o, r & ~32'h1);
    r = $urandom | 32'h2;                             // Mode bit 1 always dropped
    csr_write(CSR_OP_WRITE, CSR_MTVEC, r, 32'h0, 1'b0, 1'b0);
    expect_read("mtvec", CSR_MTVEC, {r[31:8], 7'b0, r[0]});
    check("mtvec_o mode", 32'(mtvec_o.mode), 32'({1'b0, r[0]}));

    // Killed and halted writebacks
    csr_write(CSR_OP_WRITE, CSR_MSCRATCH, ~scratch_model, scratch_model, 1'b1, 1'b0);
    expect_read("mscratch after kill", CSR_MSCRATCH, scratch_model);
    csr_write(CSR_OP_WRITE, CSR_MSCRATCH, ~scratch_model, scratch_model, 1'b0, 1'b1);
    expect_read("mscratch after halt", CSR_MSCRATCH, scratch_model);
  endtask

  task automatic test_legality();
    csr_word_t rdata;
    logic      illegal;
    logic      cnt_rd;
    csr_read(CSR_OP_WRITE, CSR_MHARTID, rdata, illegal, cnt_rd);
    check("mhartid write illegal", 32'(illegal), 32'h1);
    csr_read(CSR_OP_WRITE, UNKNOWN_ADDR, rdata, illegal, cnt_rd);
    check("unknown write illegal", 32'(illegal), 32'h1);
    csr_read(CSR_OP_SET, DCSR_ADDR, rdata, illegal, cnt_rd);
    check("dcsr set illegal", 32'(illegal), 32'h1);
    csr_read(CSR_OP_READ, UNKNOWN_ADDR, rdata, illegal, cnt_rd);
    check("unknown read data", rdata, 32'h0);
    check("unknown read illegal", 32'(illegal), 32'h1);
    expect_read("mhartid read", CSR_MHARTID, hart_id_i);
  endtask

  task automatic test_trap();
    csr_word_t trap_pc;
    csr_word_t sw_pc;
    trap_pc = $urandom;
    sw_pc   = $urandom;
    csr_write(CSR_OP_SET, CSR_MSTATUS, MSTATUS_MIE, MSTATUS_RESET_VAL, 1'b0, 1'b0);
    expect_read("mstatus mie", CSR_MSTATUS, MSTATUS_RESET_VAL | MSTATUS_MIE);
    check("m_irq_enable_o set", 32'(m_irq_enable_o), 32'h1);

    // Trap entry racing a software mepc write
    @(posedge clk);
    wb_i <= '{valid: 1'b1, csr_en: 1'b1, op: CSR_OP_WRITE, addr: CSR_MEPC, wdata: sw_pc,
              old_value: 32'h0};
    ctrl_i.save_cause <= 1'b1;
    ctrl_i.cause      <= mcause_t'(TRAP_CAUSE);
    ctrl_i.trap_pc    <= trap_pc;
    @(posedge clk);
    wb_i              <= '0;
    ctrl_i.save_cause <= 1'b0;
    @(negedge clk);
    check("m_irq_enable_o trap", 32'(m_irq_enable_o), 32'h0);
    check("mepc_o trap", mepc_o, trap_pc & ~32'h1);
    expect_read("mstatus trap", CSR_MSTATUS, MSTATUS_RESET_VAL | MSTATUS_MPIE);
    expect_read("mcause", CSR_MCAUSE, TRAP_CAUSE);

    @(posedge clk);
    ctrl_i.mret <= 1'b1;
    @(posedge clk);
    ctrl_i.mret <= 1'b0;
    @(negedge clk);
    check("m_irq_enable_o mret", 32'(m_irq_enable_o), 32'h1);
    expect_read("mstatus mret", CSR_MSTATUS, MSTATUS_RESET_VAL | MSTATUS_MIE | MSTATUS_MPIE);
  endtask

  task automatic test_counters();
    csr_word_t c0;
    csr_word_t c1;
    csr_word_t r;
    csr_word_t n_ret;
    csr_word_t n_br;
    logic      illegal;
    logic      cnt_rd;
    n_ret = 5 + ($urandom % 16);
    n_br  = 5 + ($urandom % 16);
    csr_write(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, 32'h0, MCOUNTINHIBIT_MASK, 1'b0, 1'b0);
    csr_read(CSR_OP_READ, CSR_MCYCLE, c0, illegal, cnt_rd);
    check("mcycle nonzero", 32'(c0 != 32'h0), 32'h1);
    check("counter_read_o mcycle", 32'(cnt_rd), 32'h1);
    idle(10);
    csr_read(CSR_OP_READ, CSR_MCYCLE, c1, illegal, cnt_rd);
    check("mcycle grows", 32'(c1 > c0), 32'h1);
    csr_read(CSR_OP_READ, CSR_MSCRATCH, r, illegal, cnt_rd);
    check("counter_read_o mscratch", 32'(cnt_rd), 32'h0);

    pulse_events(EV_MINSTRET, n_ret);
    idle(3);                                          // Registered event drains
    expect_read("minstret", CSR_MINSTRET, n_ret);

    csr_write(CSR_OP_WRITE, CSR_MHPMEVENT3, 32'(EV_BRANCH), 32'h0, 1'b0, 1'b0);
    expect_read("mhpmevent3", CSR_MHPMEVENT3, 32'(EV_BRANCH));
    pulse_events(EV_JUMP, 3);                         // Not selected
    pulse_events(EV_BRANCH, n_br);
    idle(3);
    expect_read("mhpmcounter3", CSR_MHPMCOUNTER3, n_br);

    r = $urandom;
    csr_write(CSR_OP_WRITE, CSR_MCYCLEH, r, 32'h0, 1'b0, 1'b0);
    expect_read("mcycleh", CSR_MCYCLEH, r);

    // Inhibit minstret only
    csr_write(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, 32'h4, 32'h0, 1'b0, 1'b0);
    expect_read("mcountinhibit", CSR_MCOUNTINHIBIT, 32'h4);
    pulse_events(EV_MINSTRET, 4);
    idle(3);
    expect_read("minstret frozen", CSR_MINSTRET, n_ret);
    expect_read("minstreth", CSR_MINSTRETH, 32'h0);
  endtask

  ////////////////////
  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

  initial begin
    void'($urandom(SEED));
    rst_n     <= 1'b0;
    hart_id_i <= $urandom;
    rd_req_i  <= '0;
    wb_i      <= '0;
    ctrl_i    <= '0;
    events_i  <= '0;
    mip_i     <= 32'h0000_0080;                       // Timer interrupt pending
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    test_reset_constants();
    test_write_set_clear();
    test_legality();
    test_trap();
    test_counters();

    if (err_cnt == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "checks failed");
    end
  end

endmodule

`default_nettype wire

//--- trap/machine_trap_regs.sv
// Machine trap registers
`timescale 1ns/1ns
`default_nettype none

module machine_trap_regs import csr_addr_pkg::*, csr_types_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  csr_wr_sel_t wr_sel_i,        // Software writes
  input  trap_ctrl_t  ctrl_i,          // Trap save and MRET
  output csr_state_t  state_o,         // To the read port
  output csr_word_t   mie_o,
  output csr_word_t   mepc_o,
  output mtvec_t      mtvec_o,
  output logic        m_irq_enable_o   // Global interrupt enable
);

  mstatus_t  mstatus_q, mstatus_n, sw_status;
  mcause_t   mcause_q, mcause_n, cause_src;
  mtvec_t    mtvec_q, mtvec_n;
  csr_word_t mie_q, mscratch_q, mepc_q, mepc_n;
  logic      mstatus_we, mepc_we, mcause_we;

  assign sw_status = mstatus_t'(wr_sel_i.wdata);

  // Legalised software values
  assign mtvec_n = '{base: wr_sel_i.wdata[31:8], mode: {1'b0, wr_sel_i.wdata[0]}, default: '0};

  ////////////////////
  // Next values with trap save over software write
  always_comb begin
    mstatus_n      = MSTATUS_RESET_VAL;      // mpp fixed at M
    mstatus_n.mie  = sw_status.mie;
    mstatus_n.mpie = sw_status.mpie;
    mstatus_we     = wr_sel_i.stb.mstatus;
    mepc_n         = wr_sel_i.wdata & ~32'd1;
    mepc_we        = wr_sel_i.stb.mepc;
    cause_src      = mcause_t'(wr_sel_i.wdata);
    mcause_we      = wr_sel_i.stb.mcause;

    if (ctrl_i.save_cause) begin
      mstatus_n      = mstatus_q;
      mstatus_n.mpie = mstatus_q.mie;        // Stack the enable
      mstatus_n.mie  = 1'b0;
      mstatus_we     = 1'b1;
      mepc_n         = ctrl_i.trap_pc & ~32'd1;
      mepc_we        = 1'b1;
      cause_src      = ctrl_i.cause;
      mcause_we      = 1'b1;
    end else if (ctrl_i.mret) begin
      mstatus_n      = mstatus_q;
      mstatus_n.mie  = mstatus_q.mpie;       // Unstack
      mstatus_n.mpie = 1'b1;
      mstatus_we     = 1'b1;
    end

    // Only irq flag and low code byte are kept
    mcause_n = '{irq: cause_src.irq, code: cause_src.code, default: '0};
  end

  ////////////////////
  // Register state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q  <= MSTATUS_RESET_VAL;
      mie_q      <= '0;
      mtvec_q    <= MTVEC_RESET_VAL;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else begin
      if (mstatus_we)            mstatus_q  <= mstatus_n;
      if (wr_sel_i.stb.mie)      mie_q      <= wr_sel_i.wdata & IRQ_MASK;
      if (wr_sel_i.stb.mtvec)    mtvec_q    <= mtvec_n;
      if (wr_sel_i.stb.mscratch) mscratch_q <= wr_sel_i.wdata;
      if (mepc_we)               mepc_q     <= mepc_n;
      if (mcause_we)             mcause_q   <= mcause_n;
    end
  end

  assign state_o = '{mstatus:  mstatus_q,
                     mie:      mie_q,
                     mtvec:    mtvec_q,
                     mscratch: mscratch_q,
                     mepc:     mepc_q,
                     mcause:   mcause_q};

  assign mie_o          = mie_q;
  assign mepc_o         = mepc_q;
  assign mtvec_o        = mtvec_q;
  assign m_irq_enable_o = mstatus_q.mie;

  // Controller never enters and leaves a trap in one cycle
  a_save_mret_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(ctrl_i.save_cause && ctrl_i.mret))
    else $error("save_cause and mret together");

endmodule

`default_nettype wire
